// File: bench/tb_axi_sram.sv
// Testbench for the AXI4 SRAM slave, single-beat transfers only
// Checking is done by concurrent assertions against expected values held here
// Window base is fixed at WIN_BASE, reads only touch words written earlier
`timescale 1ns/1ps

module tb_axi_sram;

import bus_defs_pkg::*;
import device_ids_pkg::*;

localparam logic [31:0] SEED = 32'd81741;
localparam int TIMEOUT_CYCLES = 40;                 // Per wait loop
localparam int N_WORDS = 8;                         // Words written in the full-strobe test
localparam logic [31:0] WIN_BASE = 32'h4000_2000;
localparam int SIG_AW = 0;
localparam int SIG_AR = 1;
localparam int SIG_B = 2;
localparam int SIG_R = 3;

logic i_clk;
logic i_reset;
logic i_map_load;
logic [31:0] i_map_base;
logic i_aw_valid;
logic o_aw_ready;
logic i_w_valid;
logic o_w_ready;
logic [31:0] i_aw_addr;
logic [31:0] i_w_data;
logic [31:0] i_ar_addr;
logic [7:0] i_aw_len;
logic [7:0] i_ar_len;
logic [3:0] i_w_strb;
logic o_b_valid;
logic i_b_ready;
logic i_ar_valid;
logic o_ar_ready;
logic [1:0] o_b_resp;
logic [1:0] o_r_resp;
logic o_r_valid;
logic i_r_ready;
logic o_r_last;
logic [31:0] o_r_data;
logic [15:0] o_cfg_vid;
logic [15:0] o_cfg_did;
logic [31:0] o_cfg_base;
logic [31:0] o_cfg_end;

logic [31:0] lfsr;
logic [31:0] shadow [0:1023];                       // Expected RAM contents
logic [9:0] used_word [0:N_WORDS-1];
logic [1:0] exp_b_resp;
logic [1:0] exp_r_resp;
logic [31:0] exp_r_data;
logic cfg_check;                                    // Descriptor checked while high
string cur_test;
int err_count;
int test_err_start;
int pass_count;
int fail_count;

axi_sram i_axi_sram (.*);

initial
begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;                     // 100 ns period
end

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++)
    begin
        lfsr = lfsr_step(lfsr);
        v = {v[30:0], lfsr[0]};                     // One step per bit
    end
endtask

function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                            input logic [31:0] new_word,
                                            input logic [3:0] strb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++)
        if (strb[b])
            merged[8*b +: 8] = new_word[8*b +: 8];  // Only strobed bytes change
    return merged;
endfunction

function automatic logic [31:0] word_addr(input logic [9:0] idx);
    return WIN_BASE + {20'd0, idx, 2'b00};
endfunction

function automatic logic sig_now(input int which);
    case (which)
        SIG_AW: return o_aw_ready;
        SIG_AR: return o_ar_ready;
        SIG_B: return o_b_valid;
        default: return o_r_valid;
    endcase
endfunction

task report_mismatch(input string what, input logic [31:0] expected, input logic [31:0] actual);
    $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, expected, actual);
    err_count++;
endtask

task report_plain(input string msg);
    $display("%s: %s", cur_test, msg);
    err_count++;
endtask

// Outputs looked at on the falling edge, handshake completes on the next rising edge
task wait_for(input int which, input string what);
    int cycles;
    cycles = 0;
    @(negedge i_clk);
    while (!sig_now(which) && cycles < TIMEOUT_CYCLES)
    begin
        @(negedge i_clk);
        cycles++;
    end
    if (sig_now(which))
    begin
        @(posedge i_clk);
        #5;
    end
    else
    begin
        $display("Timeout waiting for %s during %s", what, cur_test);
        $display("test failed");
        $finish;
    end
endtask

task start_write(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] strb,
                 input logic [1:0] resp);
    exp_b_resp = resp;
    i_aw_addr = addr;
    i_w_data = data;
    i_w_strb = strb;
    i_aw_valid = 1'b1;
    i_w_valid = 1'b1;
    wait_for(SIG_AW, "write address");
    i_aw_valid = 1'b0;
    i_w_valid = 1'b0;
endtask

task finish_write(input int stall);
    i_b_ready = (stall == 0);
    wait_for(SIG_B, "write response");
    if (stall > 0)
    begin
        repeat (stall) @(posedge i_clk);            // B held off
        #5;
        i_b_ready = 1'b1;
        wait_for(SIG_B, "write response after stall");
    end
    i_b_ready = 1'b0;
endtask

task start_read(input logic [31:0] addr, input logic [1:0] resp, input logic [31:0] data);
    exp_r_resp = resp;
    exp_r_data = data;
    i_ar_addr = addr;
    i_ar_valid = 1'b1;
    wait_for(SIG_AR, "read address");
    i_ar_valid = 1'b0;
endtask

task finish_read(input int stall);
    i_r_ready = (stall == 0);
    wait_for(SIG_R, "read data");
    if (stall > 0)
    begin
        repeat (stall) @(posedge i_clk);
        #5;
        i_r_ready = 1'b1;
        wait_for(SIG_R, "read data after stall");
    end
    i_r_ready = 1'b0;
endtask

task begin_test(input string name);
    cur_test = name;
    test_err_start = err_count;
endtask

task end_test;
    if (err_count == test_err_start)
        pass_count++;
    else
        fail_count++;
    $display("[%s] done, %0d errors", cur_test, err_count - test_err_start);
endtask

// Response checks on every transfer
a_b_resp: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_b_valid && i_b_ready) |-> (o_b_resp == exp_b_resp))
    else report_mismatch("write resp", 32'(exp_b_resp), 32'(o_b_resp));
a_r_resp: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_r_valid && i_r_ready) |-> (o_r_resp == exp_r_resp))
    else report_mismatch("read resp", 32'(exp_r_resp), 32'(o_r_resp));
a_r_data: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_r_valid && i_r_ready) |-> (o_r_data == exp_r_data))
    else report_mismatch("read data", exp_r_data, o_r_data);
a_r_last: assert property (@(posedge i_clk) disable iff (i_reset)
    o_r_valid |-> o_r_last)
    else report_plain("read beat came without the last flag");

// AW and W ready rise together, and only when both valids are high
a_w_ready: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_aw_ready || o_w_ready) |-> (o_aw_ready && o_w_ready && i_aw_valid && i_w_valid))
    else report_plain("write address and write data ready did not rise together");

// Back-pressure behavior
a_r_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_r_valid && !i_r_ready) |=> (o_r_valid && $stable(o_r_data)))
    else report_plain("read data dropped or changed while stalled");
a_b_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_b_valid && !i_b_ready) |=> o_b_valid)
    else report_plain("write response dropped while stalled");
a_ar_blocked: assert property (@(posedge i_clk) disable iff (i_reset)
    o_b_valid |-> !o_ar_ready)
    else report_plain("read address accepted while write response pending");

// Descriptor
a_cfg_ids: assert property (@(posedge i_clk) cfg_check |->
    ({o_cfg_vid, o_cfg_did} == {VENDOR_ID, DEVICE_ID_SRAM}))
    else report_mismatch("vendor/device", {VENDOR_ID, DEVICE_ID_SRAM}, {o_cfg_vid, o_cfg_did});
a_cfg_base: assert property (@(posedge i_clk) cfg_check |-> (o_cfg_base == WIN_BASE))
    else report_mismatch("cfg base", WIN_BASE, o_cfg_base);
a_cfg_end: assert property (@(posedge i_clk) cfg_check |-> (o_cfg_end == WIN_BASE + 32'd4095))
    else report_mismatch("cfg end", WIN_BASE + 32'd4095, o_cfg_end);

initial
begin: main_proc
    logic [31:0] rnd;
    logic [31:0] strb;
    i_reset = 1'b1;
    i_map_load = 1'b0;
    i_map_base = '0;
    i_aw_valid = 1'b0;
    i_aw_addr = '0;
    i_aw_len = '0;                                  // Single beat throughout
    i_w_valid = 1'b0;
    i_w_data = '0;
    i_w_strb = '0;
    i_b_ready = 1'b0;
    i_ar_valid = 1'b0;
    i_ar_addr = '0;
    i_ar_len = '0;
    i_r_ready = 1'b0;
    cfg_check = 1'b0;
    exp_b_resp = RESP_OKAY;
    exp_r_resp = RESP_OKAY;
    exp_r_data = '0;
    lfsr = SEED;
    err_count = 0;
    pass_count = 0;
    fail_count = 0;
    cur_test = "reset";
    repeat (10) @(posedge i_clk);
    #5;
    i_reset = 1'b0;

    begin_test("early_access");                     // Window not loaded yet
    start_write(word_addr(10'd4), 32'h1234_5678, 4'hf, RESP_SLVERR);
    finish_write(0);
    start_read(word_addr(10'd4), RESP_SLVERR, 32'h0);
    finish_read(0);
    end_test;

    begin_test("descriptor");
    i_map_base = WIN_BASE;
    i_map_load = 1'b1;
    @(posedge i_clk);
    #5;
    i_map_load = 1'b0;
    cfg_check = 1'b1;
    repeat (2) @(posedge i_clk);
    #5;
    cfg_check = 1'b0;
    end_test;

    begin_test("full_strobe");
    for (int i = 0; i < N_WORDS; i++)
    begin
        draw_bits(SRAM_WORD_BITS, rnd);
        used_word[i] = rnd[9:0];
        draw_bits(32, rnd);
        shadow[used_word[i]] = rnd;
        start_write(word_addr(used_word[i]), rnd, 4'hf, RESP_OKAY);
        finish_write(0);
    end
    for (int i = 0; i < N_WORDS; i++)
    begin
        start_read(word_addr(used_word[i]), RESP_OKAY, shadow[used_word[i]]);
        finish_read(0);
    end
    end_test;

    begin_test("partial_strobe");
    for (int i = 0; i < 4; i++)
    begin
        draw_bits(4, strb);
        draw_bits(32, rnd);
        shadow[used_word[i]] = merge_lanes(shadow[used_word[i]], rnd, strb[3:0]);
        start_write(word_addr(used_word[i]), rnd, strb[3:0], RESP_OKAY);
        finish_write(0);
        start_read(word_addr(used_word[i]), RESP_OKAY, shadow[used_word[i]]);
        finish_read(0);
    end
    end_test;

    begin_test("out_of_window");                    // Same word offset above and below window
    start_write(word_addr(used_word[1]) + SRAM_BYTE_SPAN, 32'hdead_beef, 4'hf, RESP_SLVERR);
    finish_write(0);
    start_write(word_addr(used_word[1]) - SRAM_BYTE_SPAN, 32'hfeed_f00d, 4'hf, RESP_SLVERR);
    finish_write(0);
    start_read(word_addr(used_word[1]), RESP_OKAY, shadow[used_word[1]]);
    finish_read(0);
    end_test;

    begin_test("back_pressure");
    draw_bits(32, rnd);
    shadow[used_word[0]] = rnd;
    start_write(word_addr(used_word[0]), rnd, 4'hf, RESP_OKAY);
    i_ar_addr = word_addr(used_word[0]);
    i_ar_valid = 1'b1;                              // Must wait behind the stalled B
    finish_write(6);
    start_read(word_addr(used_word[0]), RESP_OKAY, shadow[used_word[0]]);
    finish_read(6);
    end_test;

    $display("Summary: %0d tests clean, %0d tests with errors", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0)
        $display("test passed");
    else
        $display("test failed");
    $finish;
end: main_proc

endmodule: tb_axi_sram

// File: logic/axi_slave_bridge.sv
// Single-beat AXI4 slave, one transaction in flight, write has priority in idle
// Burst length must be zero, IDs and attributes are not supported
// RAM side is a plain strobe interface with one cycle of read latency
// A miss answers SLVERR with zero read data and no RAM write
`timescale 1ns/1ps

module axi_slave_bridge
(
    input  logic i_clk,
    input  logic i_reset,
    // Write address
    input  logic i_aw_valid,
    output logic o_aw_ready,
    input  logic [bus_defs_pkg::BUS_ADDR_BITS-1:0] i_aw_addr,
    input  logic [7:0] i_aw_len,
    // Write data
    input  logic i_w_valid,
    output logic o_w_ready,
    input  logic [bus_defs_pkg::BUS_DATA_BITS-1:0] i_w_data,
    input  logic [bus_defs_pkg::BUS_DATA_BYTES-1:0] i_w_strb,
    // Write response
    output logic o_b_valid,
    input  logic i_b_ready,
    output logic [1:0] o_b_resp,
    // Read address
    input  logic i_ar_valid,
    output logic o_ar_ready,
    input  logic [bus_defs_pkg::BUS_ADDR_BITS-1:0] i_ar_addr,
    input  logic [7:0] i_ar_len,
    // Read data
    output logic o_r_valid,
    input  logic i_r_ready,
    output logic [bus_defs_pkg::BUS_DATA_BITS-1:0] o_r_data,
    output logic [1:0] o_r_resp,
    output logic o_r_last,
    // Window lookup
    output logic [bus_defs_pkg::BUS_ADDR_BITS-1:0] o_lookup_addr,
    input  logic i_lookup_hit,
    input  logic [bus_defs_pkg::SRAM_WORD_BITS-1:0] i_lookup_word,
    // RAM request
    output logic o_req_valid,
    output logic o_req_write,
    output logic [bus_defs_pkg::SRAM_WORD_BITS-1:0] o_req_word,
    output logic [bus_defs_pkg::BUS_DATA_BYTES-1:0] o_req_strb,
    output logic [bus_defs_pkg::BUS_DATA_BITS-1:0] o_req_wdata,
    input  logic [bus_defs_pkg::BUS_DATA_BITS-1:0] i_resp_rdata     // Valid one cycle after read
);

import bus_defs_pkg::*;

typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_ISSUE,
    ST_WR_RESP,
    ST_RD_ISSUE,
    ST_RD_WAIT,
    ST_RD_RESP
} state_t;

state_t state;
logic aw_fire;                                  // AW and W transfer together
logic ar_fire;
logic [BUS_ADDR_BITS-1:0] addr_q;
logic [BUS_DATA_BITS-1:0] wdata_q;
logic [BUS_DATA_BYTES-1:0] strb_q;
logic rd_hit_q;                                 // Hit seen when the read was issued

// Both write channels must be valid before either is accepted
assign o_aw_ready = (state == ST_IDLE) && i_aw_valid && i_w_valid;
assign o_w_ready = o_aw_ready;
assign o_ar_ready = (state == ST_IDLE) && i_ar_valid && !(i_aw_valid && i_w_valid);
assign aw_fire = o_aw_ready;                    // Ready already implies both valids
assign ar_fire = o_ar_ready;

always_ff @(posedge i_clk)
begin: state_proc
    if (i_reset)
    begin
        state <= ST_IDLE;
        o_b_valid <= 1'b0;
        o_r_valid <= 1'b0;
    end
    else
    begin
        case (state)
        ST_IDLE:
        begin
            if (aw_fire)
                state <= ST_WR_ISSUE;
            else if (ar_fire)
                state <= ST_RD_ISSUE;
        end
        ST_WR_ISSUE:
        begin
            o_b_valid <= 1'b1;                  // RAM write on this edge
            state <= ST_WR_RESP;
        end
        ST_WR_RESP:
        begin
            if (i_b_ready)
            begin
                o_b_valid <= 1'b0;
                state <= ST_IDLE;
            end
        end
        ST_RD_ISSUE: state <= ST_RD_WAIT;       // RAM read request this cycle
        ST_RD_WAIT:
        begin
            o_r_valid <= 1'b1;
            state <= ST_RD_RESP;
        end
        ST_RD_RESP:
        begin
            if (i_r_ready)
            begin
                o_r_valid <= 1'b0;
                state <= ST_IDLE;
            end
        end
        default: state <= ST_IDLE;
        endcase
    end
end: state_proc

always_ff @(posedge i_clk)
begin: payload_proc
    if (aw_fire)
    begin
        addr_q <= i_aw_addr;
        wdata_q <= i_w_data;
        strb_q <= i_w_strb;
    end
    else if (ar_fire)
    begin
        addr_q <= i_ar_addr;
    end

    if (state == ST_WR_ISSUE)
        o_b_resp <= i_lookup_hit ? RESP_OKAY : RESP_SLVERR;
    if (state == ST_RD_ISSUE)
        rd_hit_q <= i_lookup_hit;
    if (state == ST_RD_WAIT)
    begin
        o_r_data <= rd_hit_q ? i_resp_rdata : '0;   // Zero data on a miss
        o_r_resp <= rd_hit_q ? RESP_OKAY : RESP_SLVERR;
    end
end: payload_proc

assign o_r_last = o_r_valid;                    // Every beat is the last one

// RAM request, only for addresses inside the window
assign o_lookup_addr = addr_q;
assign o_req_valid = ((state == ST_WR_ISSUE) || (state == ST_RD_ISSUE)) && i_lookup_hit;
assign o_req_write = (state == ST_WR_ISSUE);
assign o_req_word = i_lookup_word;
assign o_req_strb = strb_q;
assign o_req_wdata = wdata_q;

a_aw_single: assert property (@(posedge i_clk) disable iff (i_reset)
    aw_fire |-> (i_aw_len == 8'd0))
    else $error("Write burst not supported");

a_ar_single: assert property (@(posedge i_clk) disable iff (i_reset)
    ar_fire |-> (i_ar_len == 8'd0))
    else $error("Read burst not supported");

// Response held under back-pressure
a_r_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_r_valid && !i_r_ready) |=> (o_r_valid && $stable(o_r_data) && $stable(o_r_resp)))
    else $error("R channel changed before transfer");

a_b_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_b_valid && !i_b_ready) |=> (o_b_valid && $stable(o_b_resp)))
    else $error("B channel changed before transfer");

endmodule: axi_slave_bridge

// File: logic/axi_sram.sv
// AXI4 slave SRAM of 4 KB, single-beat transfers only
// Window must be loaded through i_map_load before any access hits
`timescale 1ns/1ps

module axi_sram
(
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_map_load,
    input  logic [bus_defs_pkg::BUS_ADDR_BITS-1:0] i_map_base,
    input  logic i_aw_valid,
    output logic o_aw_ready,
    input  logic [bus_defs_pkg::BUS_ADDR_BITS-1:0] i_aw_addr,
    input  logic [7:0] i_aw_len,
    input  logic i_w_valid,
    output logic o_w_ready,
    input  logic [bus_defs_pkg::BUS_DATA_BITS-1:0] i_w_data,
    input  logic [bus_defs_pkg::BUS_DATA_BYTES-1:0] i_w_strb,
    output logic o_b_valid,
    input  logic i_b_ready,
    output logic [1:0] o_b_resp,
    input  logic i_ar_valid,
    output logic o_ar_ready,
    input  logic [bus_defs_pkg::BUS_ADDR_BITS-1:0] i_ar_addr,
    input  logic [7:0] i_ar_len,
    output logic o_r_valid,
    input  logic i_r_ready,
    output logic [bus_defs_pkg::BUS_DATA_BITS-1:0] o_r_data,
    output logic [1:0] o_r_resp,
    output logic o_r_last,
    output logic [device_ids_pkg::CFG_ID_BITS-1:0] o_cfg_vid,      // Device descriptor
    output logic [device_ids_pkg::CFG_ID_BITS-1:0] o_cfg_did,
    output logic [bus_defs_pkg::BUS_ADDR_BITS-1:0] o_cfg_base,
    output logic [bus_defs_pkg::BUS_ADDR_BITS-1:0] o_cfg_end
);

import bus_defs_pkg::*;

logic [BUS_ADDR_BITS-1:0] wb_lookup_addr;
logic w_lookup_hit;
logic [SRAM_WORD_BITS-1:0] wb_lookup_word;
logic w_req_valid;
logic w_req_write;
logic [SRAM_WORD_BITS-1:0] wb_req_word;
logic [BUS_DATA_BYTES-1:0] wb_req_strb;
logic [BUS_DATA_BITS-1:0] wb_req_wdata;
logic [BUS_DATA_BITS-1:0] wb_resp_rdata;

slot_config cfg0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_map_load(i_map_load),
    .i_map_base(i_map_base),
    .i_lookup_addr(wb_lookup_addr),
    .o_lookup_hit(w_lookup_hit),
    .o_lookup_word(wb_lookup_word),
    .o_cfg_vid(o_cfg_vid),
    .o_cfg_did(o_cfg_did),
    .o_cfg_base(o_cfg_base),
    .o_cfg_end(o_cfg_end)
);

axi_slave_bridge xslv0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_aw_valid(i_aw_valid),
    .o_aw_ready(o_aw_ready),
    .i_aw_addr(i_aw_addr),
    .i_aw_len(i_aw_len),
    .i_w_valid(i_w_valid),
    .o_w_ready(o_w_ready),
    .i_w_data(i_w_data),
    .i_w_strb(i_w_strb),
    .o_b_valid(o_b_valid),
    .i_b_ready(i_b_ready),
    .o_b_resp(o_b_resp),
    .i_ar_valid(i_ar_valid),
    .o_ar_ready(o_ar_ready),
    .i_ar_addr(i_ar_addr),
    .i_ar_len(i_ar_len),
    .o_r_valid(o_r_valid),
    .i_r_ready(i_r_ready),
    .o_r_data(o_r_data),
    .o_r_resp(o_r_resp),
    .o_r_last(o_r_last),
    .o_lookup_addr(wb_lookup_addr),
    .i_lookup_hit(w_lookup_hit),
    .i_lookup_word(wb_lookup_word),
    .o_req_valid(w_req_valid),
    .o_req_write(w_req_write),
    .o_req_word(wb_req_word),
    .o_req_strb(wb_req_strb),
    .o_req_wdata(wb_req_wdata),
    .i_resp_rdata(wb_resp_rdata)
);

// RAM always accepts
ram_bytes tech0 (
    .i_clk(i_clk),
    .i_req_valid(w_req_valid),
    .i_req_write(w_req_write),
    .i_word(wb_req_word),
    .i_strb(wb_req_strb),
    .i_wdata(wb_req_wdata),
    .o_rdata(wb_resp_rdata)
);

endmodule: axi_sram

// File: logic/bus_defs_pkg.sv
// System bus and SRAM geometry shared by the bridge, decoder and RAM
// Data bus is one 32-bit word, so only single-word transfers are described
// Window size must stay a power of two for the base alignment rule
package bus_defs_pkg;

    // System bus widths
    localparam int BUS_ADDR_BITS   = 32;                // Byte address
    localparam int BUS_DATA_BITS   = 32;
    localparam int BUS_DATA_BYTES  = 4;                 // Byte lanes per word
    localparam int LOG2_DATA_BYTES = 2;

    // SRAM geometry
    localparam int SRAM_WORD_BITS = 10;                 // 1024 words
    localparam int unsigned SRAM_BYTE_SPAN = 4096;      // Window size in bytes, 4 KB

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;         // Returned on a window miss

endpackage: bus_defs_pkg

// File: logic/device_ids_pkg.sv
// Identifiers reported in the slot device descriptor
// Descriptor holds the base and end address words of the window
package device_ids_pkg;

    // Field widths
    localparam int CFG_ID_BITS = 16;                    // Vendor and device codes

    // Identifiers
    localparam logic [CFG_ID_BITS-1:0] VENDOR_ID      = 16'h00f1;
    localparam logic [CFG_ID_BITS-1:0] DEVICE_ID_SRAM = 16'h0073;

    // Address part of the descriptor in bytes
    localparam int CFG_DESCR_SIZE = 8;

endpackage: device_ids_pkg

// File: logic/ram_bytes.sv
// Byte-lane SRAM, contents not initialised
// o_rdata updates only on a read request and holds otherwise
`timescale 1ns/1ps

module ram_bytes
(
    input  logic i_clk,
    input  logic i_req_valid,
    input  logic i_req_write,                                   // 0 = read
    input  logic [bus_defs_pkg::SRAM_WORD_BITS-1:0] i_word,
    input  logic [bus_defs_pkg::BUS_DATA_BYTES-1:0] i_strb,     // Lane enables on write
    input  logic [bus_defs_pkg::BUS_DATA_BITS-1:0] i_wdata,
    output logic [bus_defs_pkg::BUS_DATA_BITS-1:0] o_rdata      // One cycle after read
);

import bus_defs_pkg::*;

for (genvar lane = 0; lane < BUS_DATA_BYTES; lane++)
begin: g_lane
    logic [7:0] mem [0:(2**SRAM_WORD_BITS)-1];
    logic [7:0] rdata_q;

    always_ff @(posedge i_clk)
    begin
        if (i_req_valid && i_req_write && i_strb[lane])
            mem[i_word] <= i_wdata[8*lane +: 8];        // Unstrobed lanes keep old data
        if (i_req_valid && !i_req_write)
            rdata_q <= mem[i_word];
    end

    assign o_rdata[8*lane +: 8] = rdata_q;
end: g_lane

endmodule: ram_bytes

// File: logic/slot_config.sv
// Window is disabled after reset, so every lookup misses until i_map_load
// i_map_base must be aligned to the window span
// Decode is combinational with no latency
`timescale 1ns/1ps

module slot_config
(
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_map_load,                                        // One-cycle load strobe
    input  logic [bus_defs_pkg::BUS_ADDR_BITS-1:0] i_map_base,      // Window base
    input  logic [bus_defs_pkg::BUS_ADDR_BITS-1:0] i_lookup_addr,   // From bridge
    output logic o_lookup_hit,
    output logic [bus_defs_pkg::SRAM_WORD_BITS-1:0] o_lookup_word,  // Word offset in window
    output logic [device_ids_pkg::CFG_ID_BITS-1:0] o_cfg_vid,
    output logic [device_ids_pkg::CFG_ID_BITS-1:0] o_cfg_did,
    output logic [bus_defs_pkg::BUS_ADDR_BITS-1:0] o_cfg_base,
    output logic [bus_defs_pkg::BUS_ADDR_BITS-1:0] o_cfg_end
);

import bus_defs_pkg::*;
import device_ids_pkg::*;

logic [BUS_ADDR_BITS-1:0] base_q;
logic win_en_q;                                 // Window valid once loaded
logic [BUS_ADDR_BITS-1:0] offset;               // Byte offset from base

// Base and end words must fill the address part of the descriptor
if (CFG_DESCR_SIZE * 8 != 2 * BUS_ADDR_BITS)
begin: g_descr_check
    $error("Descriptor size does not match the address fields");
end: g_descr_check

always_ff @(posedge i_clk)
begin: map_proc
    if (i_reset)
    begin
        win_en_q <= 1'b0;
        base_q <= '0;
    end
    else if (i_map_load)
    begin
        win_en_q <= 1'b1;
        base_q <= i_map_base;
    end
end: map_proc

always_comb
begin: decode_proc
    offset = i_lookup_addr - base_q;            // Wraps high when below base
    o_lookup_hit = win_en_q && (offset < SRAM_BYTE_SPAN);
    o_lookup_word = offset[LOG2_DATA_BYTES +: SRAM_WORD_BITS];
end: decode_proc

// Descriptor
assign o_cfg_vid = VENDOR_ID;
assign o_cfg_did = DEVICE_ID_SRAM;
assign o_cfg_base = base_q;
assign o_cfg_end = base_q + BUS_ADDR_BITS'(SRAM_BYTE_SPAN - 1);    // Last byte in window

a_base_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
    i_map_load |-> ((i_map_base & BUS_ADDR_BITS'(SRAM_BYTE_SPAN - 1)) == '0))
    else $error("Window base not aligned to span");

endmodule: slot_config

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it into sim.log and checks the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_axi_sram \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_axi_sram > sim.log 2>&1 \
    || echo "Build or simulation did not complete, see build.log and sim.log"
grep -qx "test passed" sim.log && ! grep -q "test failed" sim.log \
    && echo "Simulation result: PASS" && exit 0 \
    || { echo "Simulation result: FAIL"; exit 1; }

// File: verilog.f
logic/bus_defs_pkg.sv
logic/device_ids_pkg.sv
logic/slot_config.sv
logic/axi_slave_bridge.sv
logic/ram_bytes.sv
logic/axi_sram.sv
bench/tb_axi_sram.sv
